/* common/rv_pkg.sv */
package rv_pkg;

    localparam int xlen       = 32;
    localparam int imem_depth = 64;
    localparam int dmem_depth = 64;
    localparam int imem_aw    = 6;

    // Base opcodes of the supported RV32I subset
    localparam logic [6:0] op_rtype  = 7'b0110011;
    localparam logic [6:0] op_itype  = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_lui    = 7'b0110111;

    localparam logic [31:0] nop_instr = 32'h0000_0013; // addi x0, x0, 0

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_slt, alu_pass_b
    } alu_op_t;

    // Operand source in execute
    typedef enum logic [1:0] {
        fwd_rf, fwd_mem, fwd_wb
    } fwd_sel_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One instruction word, six views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_t;

endpackage

/* rtl/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [31:0]             instr_i,
    input  logic [rv_pkg::xlen-1:0] pc_i,
    input  logic                    stall_i,
    input  logic                    flush_i,
    input  logic                    wb_we_i,
    input  logic [4:0]              wb_rd_i,
    input  logic [rv_pkg::xlen-1:0] wb_data_i,
    output logic [4:0]              rs1_o,
    output logic [4:0]              rs2_o,
    output logic [4:0]              rd_o,
    output logic [rv_pkg::xlen-1:0] rs1_val_o,
    output logic [rv_pkg::xlen-1:0] rs2_val_o,
    output logic [rv_pkg::xlen-1:0] imm_o,
    output logic [rv_pkg::xlen-1:0] pc_e_o,
    output rv_pkg::alu_op_t         alu_op_o,
    output logic                    alu_src_imm_o,
    output logic                    we_o,
    output logic                    load_o,
    output logic                    store_o,
    output logic                    branch_o,
    output logic                    jal_o,
    output logic [2:0]              funct3_o,
    output logic [4:0]              rs1_d_o,
    output logic [4:0]              rs2_d_o,
    output logic [rv_pkg::xlen-1:0] a0_o
);
    import rv_pkg::*;

    instr_t          ins;
    logic [xlen-1:0] regs [32];
    logic [xlen-1:0] rs1_val, rs2_val, imm_d;
    alu_op_t         alu_op_d;
    logic            src_imm_d, we_d, load_d, store_d, branch_d, jal_d;

    assign ins     = instr_i;
    assign rs1_d_o = ins.r.rs1;
    assign rs2_d_o = ins.r.rs2;

    // Control and immediate, picked by opcode
    always_comb begin
        alu_op_d  = alu_add;
        src_imm_d = 1'b0;
        we_d      = 1'b0;
        load_d    = 1'b0;
        store_d   = 1'b0;
        branch_d  = 1'b0;
        jal_d     = 1'b0;
        imm_d     = {{20{ins.i.imm[11]}}, ins.i.imm};
        case (ins.r.opcode)
            op_rtype: begin
                we_d = 1'b1;
                case (ins.r.funct3)
                    3'b111:  alu_op_d = alu_and;
                    3'b110:  alu_op_d = alu_or;
                    3'b010:  alu_op_d = alu_slt;
                    default: alu_op_d = ins.r.funct7[5] ? alu_sub : alu_add;
                endcase
            end
            op_itype: begin
                we_d      = 1'b1;
                src_imm_d = 1'b1;
                case (ins.i.funct3)
                    3'b111:  alu_op_d = alu_and; // ANDI
                    3'b110:  alu_op_d = alu_or;  // ORI
                    default: alu_op_d = alu_add;
                endcase
            end
            op_load: begin
                we_d      = 1'b1;
                load_d    = 1'b1;
                src_imm_d = 1'b1;
            end
            op_store: begin
                store_d   = 1'b1;
                src_imm_d = 1'b1;
                imm_d     = {{20{ins.s.imm_hi[6]}}, ins.s.imm_hi, ins.s.imm_lo};
            end
            op_branch: begin
                branch_d = 1'b1;
                imm_d    = {{19{ins.b.imm12}}, ins.b.imm12, ins.b.imm11,
                            ins.b.imm10_5, ins.b.imm4_1, 1'b0};
            end
            op_jal: begin
                we_d  = 1'b1;
                jal_d = 1'b1;
                imm_d = {{11{ins.j.imm20}}, ins.j.imm20, ins.j.imm19_12,
                         ins.j.imm11, ins.j.imm10_1, 1'b0};
            end
            op_lui: begin
                we_d      = 1'b1;
                src_imm_d = 1'b1;
                alu_op_d  = alu_pass_b;
                imm_d     = {ins.u.imm, 12'b0};
            end
            default: ;
        endcase
    end

    // Register file, x0 never written
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (wb_we_i && wb_rd_i != 5'd0) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    // Same-cycle writeback is seen by the read
    assign rs1_val = (ins.r.rs1 == 5'd0) ? '0 :
                     (wb_we_i && wb_rd_i == ins.r.rs1) ? wb_data_i : regs[ins.r.rs1];
    assign rs2_val = (ins.r.rs2 == 5'd0) ? '0 :
                     (wb_we_i && wb_rd_i == ins.r.rs2) ? wb_data_i : regs[ins.r.rs2];
    assign a0_o    = regs[10];

    // Decode/execute control, bubble on stall or flush
    always_ff @(posedge clk or posedge rst) begin
        if (rst || stall_i || flush_i) begin
            we_o     <= 1'b0;
            load_o   <= 1'b0;
            store_o  <= 1'b0;
            branch_o <= 1'b0;
            jal_o    <= 1'b0;
            rd_o     <= '0;
            rs1_o    <= '0;
            rs2_o    <= '0;
        end else begin
            we_o     <= we_d;
            load_o   <= load_d;
            store_o  <= store_d;
            branch_o <= branch_d;
            jal_o    <= jal_d;
            rd_o     <= ins.r.rd;
            rs1_o    <= ins.r.rs1;
            rs2_o    <= ins.r.rs2;
        end
    end

    // Payload side
    always_ff @(posedge clk) begin
        rs1_val_o     <= rs1_val;
        rs2_val_o     <= rs2_val;
        imm_o         <= imm_d;
        pc_e_o        <= pc_i;
        alu_op_o      <= alu_op_d;
        alu_src_imm_o <= src_imm_d;
        funct3_o      <= ins.r.funct3;
    end

endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [4:0]              rd_i,
    input  logic [rv_pkg::xlen-1:0] rs1_val_i,
    input  logic [rv_pkg::xlen-1:0] rs2_val_i,
    input  logic [rv_pkg::xlen-1:0] imm_i,
    input  logic [rv_pkg::xlen-1:0] pc_i,
    input  rv_pkg::alu_op_t         alu_op_i,
    input  logic                    alu_src_imm_i,
    input  logic                    we_i,
    input  logic                    load_i,
    input  logic                    store_i,
    input  logic                    branch_i,
    input  logic                    jal_i,
    input  logic [2:0]              funct3_i,
    input  rv_pkg::fwd_sel_t        fwd_a_i,
    input  rv_pkg::fwd_sel_t        fwd_b_i,
    input  logic [rv_pkg::xlen-1:0] mem_fwd_i,
    input  logic [rv_pkg::xlen-1:0] wb_fwd_i,
    output logic                    branch_taken_o,
    output logic [rv_pkg::xlen-1:0] branch_target_o,
    output logic [rv_pkg::xlen-1:0] alu_result_o,
    output logic [rv_pkg::xlen-1:0] store_data_o,
    output logic [4:0]              rd_m_o,
    output logic                    we_m_o,
    output logic                    load_m_o,
    output logic                    store_m_o,
    output logic [rv_pkg::xlen-1:0] link_m_o,
    output logic                    jal_m_o,
    output logic [4:0]              rd_e_o,
    output logic                    we_e_o,
    output logic                    load_e_o
);
    import rv_pkg::*;

    logic [xlen-1:0] opa, opb, src_b, alu_y;
    logic            cond;

    // Forwarding muxes
    always_comb begin
        case (fwd_a_i)
            fwd_mem: opa = mem_fwd_i;
            fwd_wb:  opa = wb_fwd_i;
            default: opa = rs1_val_i;
        endcase
        case (fwd_b_i)
            fwd_mem: opb = mem_fwd_i;
            fwd_wb:  opb = wb_fwd_i;
            default: opb = rs2_val_i;
        endcase
    end

    assign src_b = alu_src_imm_i ? imm_i : opb;

    always_comb begin
        case (alu_op_i)
            alu_sub:    alu_y = opa - src_b;
            alu_and:    alu_y = opa & src_b;
            alu_or:     alu_y = opa | src_b;
            alu_slt:    alu_y = {{(xlen-1){1'b0}}, $signed(opa) < $signed(src_b)};
            alu_pass_b: alu_y = src_b; // LUI
            default:    alu_y = opa + src_b;
        endcase
    end

    // Branch compare on the forwarded register values
    always_comb begin
        case (funct3_i)
            3'b000:  cond = (opa == opb);                   // BEQ
            3'b001:  cond = (opa != opb);                   // BNE
            3'b100:  cond = ($signed(opa) < $signed(opb));  // BLT
            default: cond = 1'b0;
        endcase
    end

    assign branch_taken_o  = jal_i || (branch_i && cond);
    assign branch_target_o = pc_i + imm_i;

    assign rd_e_o   = rd_i;
    assign we_e_o   = we_i;
    assign load_e_o = load_i;

    // Execute/memory register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_m_o    <= '0;
            we_m_o    <= 1'b0;
            load_m_o  <= 1'b0;
            store_m_o <= 1'b0;
            jal_m_o   <= 1'b0;
        end else begin
            rd_m_o    <= rd_i;
            we_m_o    <= we_i;
            load_m_o  <= load_i;
            store_m_o <= store_i;
            jal_m_o   <= jal_i;
        end
    end

    always_ff @(posedge clk) begin
        alu_result_o <= alu_y;
        store_data_o <= opb;
        link_m_o     <= pc_i + xlen'(4); // Return address for JAL
    end

endmodule

/* rtl/fetch_stage.sv */
`timescale 1ns/1ns

module fetch_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      trigger_i,
    input  logic                      imem_wr_en_i,
    input  logic [rv_pkg::imem_aw-1:0] imem_addr_i,
    input  logic [rv_pkg::xlen-1:0]   imem_wdata_i,
    input  logic                      stall_i,
    input  logic                      flush_i,
    input  logic                      branch_taken_i,
    input  logic [rv_pkg::xlen-1:0]   branch_target_i,
    output logic [31:0]               instr_d_o,
    output logic [rv_pkg::xlen-1:0]   pc_d_o,
    output logic [rv_pkg::xlen-1:0]   pc_o
);
    import rv_pkg::*;

    logic            started;
    logic [xlen-1:0] pc_q;
    logic [31:0]     imem [imem_depth];
    logic [31:0]     instr_f;

    // Start latch, set once and held until reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            started <= 1'b0;
        end else if (trigger_i) begin
            started <= 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_q <= '0;
        end else if (branch_taken_i) begin
            pc_q <= branch_target_i; // Redirect from execute
        end else if (started && !stall_i) begin
            pc_q <= pc_q + xlen'(4);
        end
    end

    // Program load port, only used while idle
    always_ff @(posedge clk) begin
        if (imem_wr_en_i) begin
            imem[imem_addr_i] <= imem_wdata_i;
        end
    end

    assign instr_f = imem[pc_q[imem_aw+1:2]]; // Word addressed

    // Fetch/decode register, NOP until the core is started
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            instr_d_o <= nop_instr;
            pc_d_o    <= '0;
        end else if (!started || flush_i) begin
            instr_d_o <= nop_instr;
        end else if (!stall_i) begin
            instr_d_o <= instr_f;
            pc_d_o    <= pc_q;
        end
    end

    assign pc_o = pc_q;

endmodule

/* rtl/hazard_unit.sv */
`timescale 1ns/1ns

module hazard_unit (
    input  logic [4:0]       rs1_d_i,
    input  logic [4:0]       rs2_d_i,
    input  logic [4:0]       rs1_e_i,
    input  logic [4:0]       rs2_e_i,
    input  logic [4:0]       rd_e_i,
    input  logic             load_e_i,
    input  logic [4:0]       rd_m_i,
    input  logic             we_m_i,
    input  logic [4:0]       rd_w_i,
    input  logic             we_w_i,
    input  logic             branch_taken_i,
    output rv_pkg::fwd_sel_t fwd_a_o,
    output rv_pkg::fwd_sel_t fwd_b_o,
    output logic             stall_o,
    output logic             flush_o
);
    import rv_pkg::*;

    // Youngest producer wins
    function automatic fwd_sel_t pick_src(input logic [4:0] rs);
        if (rs == 5'd0) begin
            return fwd_rf;
        end else if (we_m_i && rd_m_i == rs) begin
            return fwd_mem;
        end else if (we_w_i && rd_w_i == rs) begin
            return fwd_wb;
        end
        return fwd_rf;
    endfunction

    assign fwd_a_o = pick_src(rs1_e_i);
    assign fwd_b_o = pick_src(rs2_e_i);

    // Load data is only ready from writeback
    assign stall_o = load_e_i && rd_e_i != 5'd0 &&
                     (rd_e_i == rs1_d_i || rd_e_i == rs2_d_i);
    assign flush_o = branch_taken_i;

endmodule

/* rtl/mem_wb_stage.sv */
`timescale 1ns/1ns

module mem_wb_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [rv_pkg::xlen-1:0] alu_result_i,
    input  logic [rv_pkg::xlen-1:0] store_data_i,
    input  logic [4:0]              rd_i,
    input  logic                    we_i,
    input  logic                    load_i,
    input  logic                    store_i,
    input  logic [rv_pkg::xlen-1:0] link_i,
    input  logic                    jal_i,
    output logic [rv_pkg::xlen-1:0] mem_result_o,
    output logic                    wb_we_o,
    output logic [4:0]              wb_rd_o,
    output logic [rv_pkg::xlen-1:0] wb_data_o,
    output logic [4:0]              rd_m_o,
    output logic                    we_m_o
);
    import rv_pkg::*;

    logic [xlen-1:0] dmem [dmem_depth];
    logic [xlen-1:0] load_data, load_w, alu_w, link_w;
    logic            load_sel_w, jal_sel_w;

    always_ff @(posedge clk) begin
        if (store_i) begin
            dmem[alu_result_i[$clog2(dmem_depth)+1:2]] <= store_data_i;
        end
    end

    assign load_data = dmem[alu_result_i[$clog2(dmem_depth)+1:2]];

    // A JAL in memory forwards its link value
    assign mem_result_o = jal_i ? link_i : alu_result_i;
    assign rd_m_o       = rd_i;
    assign we_m_o       = we_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_we_o    <= 1'b0;
            wb_rd_o    <= '0;
            load_sel_w <= 1'b0;
            jal_sel_w  <= 1'b0;
        end else begin
            wb_we_o    <= we_i;
            wb_rd_o    <= rd_i;
            load_sel_w <= load_i;
            jal_sel_w  <= jal_i;
        end
    end

    always_ff @(posedge clk) begin
        load_w <= load_data;
        alu_w  <= alu_result_i;
        link_w <= link_i;
    end

    assign wb_data_o = load_sel_w ? load_w :
                       jal_sel_w  ? link_w : alu_w;

endmodule

/* rtl/rv_core_top.sv */
`timescale 1ns/1ns

module rv_core_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       trigger_i,
    input  logic                       imem_wr_en_i,
    input  logic [rv_pkg::imem_aw-1:0] imem_addr_i,
    input  logic [rv_pkg::xlen-1:0]    imem_wdata_i,
    output logic [rv_pkg::xlen-1:0]    a0_o,
    output logic [rv_pkg::xlen-1:0]    pc_o
);
    import rv_pkg::*;

    logic            stall, flush, branch_taken;
    logic [xlen-1:0] branch_target, instr_d, pc_d;
    logic [4:0]      rs1_e, rs2_e, rd_e, rs1_d, rs2_d, rd_x, rd_m, rd_mh, wb_rd;
    logic [xlen-1:0] rs1_val_e, rs2_val_e, imm_e, pc_e;
    alu_op_t         alu_op_e;
    logic            alu_src_imm_e, we_e, load_e, store_e, branch_e, jal_e, load_x;
    logic [2:0]      funct3_e;
    fwd_sel_t        fwd_a, fwd_b;
    logic [xlen-1:0] alu_result_m, store_data_m, link_m, mem_result, wb_data;
    logic            we_m, load_m, store_m, jal_m, we_mh, wb_we;

    fetch_stage u_fetch (
        .clk, .rst, .trigger_i, .imem_wr_en_i, .imem_addr_i, .imem_wdata_i,
        .stall_i(stall), .flush_i(flush),
        .branch_taken_i(branch_taken), .branch_target_i(branch_target),
        .instr_d_o(instr_d), .pc_d_o(pc_d), .pc_o
    );

    decode_stage u_decode (
        .clk, .rst, .instr_i(instr_d), .pc_i(pc_d),
        .stall_i(stall), .flush_i(flush),
        .wb_we_i(wb_we), .wb_rd_i(wb_rd), .wb_data_i(wb_data),
        .rs1_o(rs1_e), .rs2_o(rs2_e), .rd_o(rd_e),
        .rs1_val_o(rs1_val_e), .rs2_val_o(rs2_val_e), .imm_o(imm_e), .pc_e_o(pc_e),
        .alu_op_o(alu_op_e), .alu_src_imm_o(alu_src_imm_e), .we_o(we_e),
        .load_o(load_e), .store_o(store_e), .branch_o(branch_e), .jal_o(jal_e),
        .funct3_o(funct3_e), .rs1_d_o(rs1_d), .rs2_d_o(rs2_d), .a0_o
    );

    execute_stage u_execute (
        .clk, .rst, .rd_i(rd_e), .rs1_val_i(rs1_val_e), .rs2_val_i(rs2_val_e),
        .imm_i(imm_e), .pc_i(pc_e), .alu_op_i(alu_op_e), .alu_src_imm_i(alu_src_imm_e),
        .we_i(we_e), .load_i(load_e), .store_i(store_e), .branch_i(branch_e),
        .jal_i(jal_e), .funct3_i(funct3_e), .fwd_a_i(fwd_a), .fwd_b_i(fwd_b),
        .mem_fwd_i(mem_result), .wb_fwd_i(wb_data),
        .branch_taken_o(branch_taken), .branch_target_o(branch_target),
        .alu_result_o(alu_result_m), .store_data_o(store_data_m), .rd_m_o(rd_m),
        .we_m_o(we_m), .load_m_o(load_m), .store_m_o(store_m), .link_m_o(link_m),
        .jal_m_o(jal_m), .rd_e_o(rd_x), .we_e_o(), .load_e_o(load_x)
    );

    mem_wb_stage u_mem_wb (
        .clk, .rst, .alu_result_i(alu_result_m), .store_data_i(store_data_m),
        .rd_i(rd_m), .we_i(we_m), .load_i(load_m), .store_i(store_m),
        .link_i(link_m), .jal_i(jal_m), .mem_result_o(mem_result),
        .wb_we_o(wb_we), .wb_rd_o(wb_rd), .wb_data_o(wb_data),
        .rd_m_o(rd_mh), .we_m_o(we_mh)
    );

    hazard_unit u_hazard (
        .rs1_d_i(rs1_d), .rs2_d_i(rs2_d), .rs1_e_i(rs1_e), .rs2_e_i(rs2_e),
        .rd_e_i(rd_x), .load_e_i(load_x), .rd_m_i(rd_mh), .we_m_i(we_mh),
        .rd_w_i(wb_rd), .we_w_i(wb_we), .branch_taken_i(branch_taken),
        .fwd_a_o(fwd_a), .fwd_b_o(fwd_b), .stall_o(stall), .flush_o(flush)
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module rv_core_tb \
    -Mdir obj_dir -o rv_core_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit $build_status
fi

./obj_dir/rv_core_sim
run_status=$?
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit $run_status
fi

exit 0

/* sim.f */
common/rv_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/hazard_unit.sv
rtl/rv_core_top.sv
verif/rv_core_asserts.sv
verif/rv_core_tb.sv

/* verif/rv_core_asserts.sv */
`timescale 1ns/1ns

module rv_core_asserts (
    input logic       clk,
    input logic       rst,
    input logic       flush_i,
    input logic       stall_i,
    input logic       we_e_i,
    input logic [4:0] rd_e_i,
    input logic       started_i,
    input logic       imem_wr_en_i
);

    // Both slots behind a taken branch are squashed
    a_flush_bubble: assert property (@(posedge clk) disable iff (rst)
        flush_i |=> (!we_e_i || rd_e_i == 5'd0) [*2])
        else $error("write-enabled instruction entered execute after a flush");

    a_stall_single: assert property (@(posedge clk) disable iff (rst)
        stall_i |=> !stall_i)
        else $error("load-use stall lasted more than one cycle");

    a_no_imem_write: assert property (@(posedge clk) disable iff (rst)
        started_i |-> !imem_wr_en_i)
        else $error("instruction memory written while the core runs");

endmodule

bind rv_core_top rv_core_asserts u_asserts (
    .clk(clk),
    .rst(rst),
    .flush_i(flush),
    .stall_i(stall),
    .we_e_i(we_e),
    .rd_e_i(rd_e),
    .started_i(u_fetch.started),
    .imem_wr_en_i(imem_wr_en_i)
);

/* verif/rv_core_tb.sv */
`timescale 1ns/1ns

module rv_core_tb;
    import rv_pkg::*;

    logic               clk;
    logic               rst;
    logic               trigger_i;
    logic               imem_wr_en_i;
    logic [imem_aw-1:0] imem_addr_i;
    logic [xlen-1:0]    imem_wdata_i;
    logic [xlen-1:0]    a0_o;
    logic [xlen-1:0]    pc_o;

    logic [31:0] prog [imem_depth]; // Program image, also read by the reference model
    int          prog_len;
    logic [31:0] final_addr;
    int          seed;

    rv_core_top dut (
        .clk(clk), .rst(rst), .trigger_i(trigger_i),
        .imem_wr_en_i(imem_wr_en_i), .imem_addr_i(imem_addr_i),
        .imem_wdata_i(imem_wdata_i), .a0_o(a0_o), .pc_o(pc_o)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, op_rtype};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, op_lui};
    endfunction

    // Architectural model of the subset, one instruction per step
    function automatic logic [31:0] ref_a0(input int steps);
        logic [31:0] r [32];
        logic [31:0] dm [dmem_depth];
        logic [31:0] pc, next_pc, imm, a, b, res, addr;
        logic        wr;
        instr_t      w;
        for (int k = 0; k < 32; k++) begin
            r[k] = '0;
        end
        for (int k = 0; k < dmem_depth; k++) begin
            dm[k] = '0;
        end
        pc = '0;
        for (int n = 0; n < steps; n++) begin
            w       = prog[pc[imem_aw+1:2]];
            a       = r[w.r.rs1];
            b       = r[w.r.rs2];
            next_pc = pc + 32'd4;
            wr      = 1'b0;
            res     = '0;
            case (w.r.opcode)
                op_rtype: begin
                    wr = 1'b1;
                    case (w.r.funct3)
                        3'b000:  res = w.r.funct7[5] ? a - b : a + b;
                        3'b111:  res = a & b;
                        3'b110:  res = a | b;
                        3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: res = '0;
                    endcase
                end
                op_itype: begin
                    wr  = 1'b1;
                    imm = {{20{w.i.imm[11]}}, w.i.imm};
                    case (w.i.funct3)
                        3'b111:  res = a & imm;
                        3'b110:  res = a | imm;
                        default: res = a + imm;
                    endcase
                end
                op_lui: begin
                    wr  = 1'b1;
                    res = {w.u.imm, 12'h000};
                end
                op_load: begin
                    wr   = 1'b1;
                    addr = a + {{20{w.i.imm[11]}}, w.i.imm};
                    res  = dm[addr[7:2]];
                end
                op_store: begin
                    addr = a + {{20{w.s.imm_hi[6]}}, w.s.imm_hi, w.s.imm_lo};
                    dm[addr[7:2]] = b;
                end
                op_branch: begin
                    imm = {{19{w.b.imm12}}, w.b.imm12, w.b.imm11, w.b.imm10_5,
                           w.b.imm4_1, 1'b0};
                    if ((w.b.funct3 == 3'b000 && a == b) ||
                        (w.b.funct3 == 3'b001 && a != b) ||
                        (w.b.funct3 == 3'b100 && $signed(a) < $signed(b))) begin
                        next_pc = pc + imm;
                    end
                end
                op_jal: begin
                    wr      = 1'b1;
                    res     = pc + 32'd4;
                    imm     = {{11{w.j.imm20}}, w.j.imm20, w.j.imm19_12, w.j.imm11,
                               w.j.imm10_1, 1'b0};
                    next_pc = pc + imm;
                end
                default: ;
            endcase
            if (wr && w.r.rd != 5'd0) begin
                r[w.r.rd] = res;
            end
            pc = next_pc;
        end
        return r[10];
    endfunction

    task automatic tick();
        @(posedge clk);
        #5;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH test=%s expected=0x%08h actual=0x%08h", name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic apply_reset();
        rst       = 1'b1;
        trigger_i = 1'b0;
        repeat (8) tick();
        rst = 1'b0;
        tick();
    endtask

    task automatic begin_program();
        prog_len = 0;
        for (int k = 0; k < imem_depth; k++) begin
            prog[k] = nop_instr;
        end
    endtask

    task automatic emit(input logic [31:0] word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    // Self-loop closes every program
    task automatic end_program();
        final_addr = 32'(prog_len * 4);
        emit(enc_j(21'd0, 5'd0));
    endtask

    task automatic load_program();
        for (int k = 0; k < imem_depth; k++) begin
            imem_wr_en_i = 1'b1;
            imem_addr_i  = imem_aw'(k);
            imem_wdata_i = prog[k];
            tick();
        end
        imem_wr_en_i = 1'b0;
        tick();
    endtask

    task automatic run_program(input string name);
        logic [31:0] expected;
        int          c;
        apply_reset();
        load_program();
        trigger_i = 1'b1;
        tick();
        trigger_i = 1'b0;
        for (c = 0; c < 500 && pc_o != final_addr; c++) begin
            tick();
        end
        if (pc_o != final_addr) begin
            $display("Timeout: program %s never reached its final loop", name);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout waiting for completion");
        end
        repeat (10) tick();
        expected = ref_a0(200);
        check_value(name, expected, a0_o);
    endtask

    // x1..x7 and a0
    function automatic logic [4:0] pick_reg(input logic [2:0] v);
        return (v == 3'd0) ? 5'd10 : {2'b00, v};
    endfunction

    task automatic build_random();
        logic [31:0] r;
        logic [3:0]  sel;
        logic [4:0]  rd, rs1, rs2;
        begin_program();
        for (int k = 0; k < 12; k++) begin
            r   = $random(seed);
            sel = r[3:0] % 4'd9;
            rd  = pick_reg(r[6:4]);
            rs1 = pick_reg(r[9:7]);
            rs2 = pick_reg(r[12:10]);
            case (sel)
                4'd0: emit(enc_r(7'h00, rs2, rs1, 3'b000, rd));
                4'd1: emit(enc_r(7'h20, rs2, rs1, 3'b000, rd));
                4'd2: emit(enc_r(7'h00, rs2, rs1, 3'b111, rd));
                4'd3: emit(enc_r(7'h00, rs2, rs1, 3'b110, rd));
                4'd4: emit(enc_r(7'h00, rs2, rs1, 3'b010, rd));
                4'd5: emit(enc_i(r[31:20], rs1, 3'b000, rd, op_itype));
                4'd6: emit(enc_i(r[31:20], rs1, 3'b111, rd, op_itype));
                4'd7: emit(enc_i(r[31:20], rs1, 3'b110, rd, op_itype));
                default: emit(enc_u(r[31:12], rd));
            endcase
        end
        r = $random(seed);
        emit(enc_r(7'h00, pick_reg(r[2:0]), 5'd10, 3'b000, 5'd10)); // Fold into a0
        end_program();
    endtask

    initial begin
        seed         = 32'ha07c;
        rst          = 1'b1;
        trigger_i    = 1'b0;
        imem_wr_en_i = 1'b0;
        imem_addr_i  = '0;
        imem_wdata_i = '0;

        // Idle core before start
        apply_reset();
        for (int k = 0; k < 20; k++) begin
            check_value("idle_pc", 32'd0, pc_o);
            check_value("idle_a0", 32'd0, a0_o);
            tick();
        end

        begin_program();
        emit(enc_i(12'd5, 5'd0, 3'b000, 5'd1, op_itype));
        emit(enc_i(12'd7, 5'd1, 3'b000, 5'd2, op_itype));
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        emit(enc_r(7'h20, 5'd1, 5'd3, 3'b000, 5'd4));
        emit(enc_r(7'h00, 5'd3, 5'd4, 3'b111, 5'd5));
        emit(enc_r(7'h00, 5'd3, 5'd4, 3'b110, 5'd6));
        emit(enc_r(7'h00, 5'd6, 5'd1, 3'b010, 5'd7));
        emit(enc_r(7'h00, 5'd7, 5'd6, 3'b000, 5'd10));
        end_program();
        run_program("forwarding_chain");

        begin_program();
        emit(enc_i(12'd77, 5'd0, 3'b000, 5'd1, op_itype));
        emit(enc_i(12'd8, 5'd0, 3'b000, 5'd2, op_itype));
        emit(enc_s(12'd0, 5'd1, 5'd2));
        emit(enc_i(12'd0, 5'd2, 3'b010, 5'd3, op_load));
        emit(enc_r(7'h00, 5'd1, 5'd3, 3'b000, 5'd10)); // Load-use
        end_program();
        run_program("store_load_use");

        begin_program();
        emit(enc_i(12'd1, 5'd0, 3'b000, 5'd10, op_itype));
        emit(enc_i(12'd3, 5'd0, 3'b000, 5'd1, op_itype));
        emit(enc_b(13'd8, 5'd1, 5'd1, 3'b000));
        emit(enc_i(12'd100, 5'd10, 3'b000, 5'd10, op_itype));
        emit(enc_b(13'd12, 5'd0, 5'd1, 3'b001));
        emit(enc_i(12'd200, 5'd10, 3'b000, 5'd10, op_itype));
        emit(enc_i(12'd300, 5'd10, 3'b000, 5'd10, op_itype));
        emit(enc_b(13'd8, 5'd1, 5'd0, 3'b100));
        emit(enc_i(12'd400, 5'd10, 3'b000, 5'd10, op_itype));
        emit(enc_b(13'd8, 5'd0, 5'd1, 3'b000));        // Not taken from here on
        emit(enc_i(12'd2, 5'd10, 3'b000, 5'd10, op_itype));
        emit(enc_b(13'd8, 5'd1, 5'd1, 3'b001));
        emit(enc_i(12'd4, 5'd10, 3'b000, 5'd10, op_itype));
        emit(enc_b(13'd8, 5'd0, 5'd1, 3'b100));
        emit(enc_i(12'd8, 5'd10, 3'b000, 5'd10, op_itype));
        end_program();
        run_program("branches");

        begin_program();
        emit(enc_j(21'd8, 5'd10));
        emit(enc_i(12'd1000, 5'd10, 3'b000, 5'd10, op_itype));
        emit(enc_u(20'h12345, 5'd11));
        emit(enc_i(12'h678, 5'd11, 3'b000, 5'd11, op_itype));
        emit(enc_r(7'h00, 5'd11, 5'd10, 3'b000, 5'd10));
        emit(enc_u(20'h80000, 5'd12));
        emit(enc_r(7'h00, 5'd12, 5'd10, 3'b110, 5'd10));
        end_program();
        run_program("jal_lui");

        for (int t = 0; t < 20; t++) begin
            build_random();
            run_program($sformatf("random_%0d", t));
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
